//--- hw/wave_pkg.sv
package wave_pkg;

  //////////////////////////////////////////////////////////////////////////
  // data widths
  //////////////////////////////////////////////////////////////////////////

  typedef logic [15:0] pipe_word_t;   // one host word on the pipe port
  typedef logic [31:0] wave_word_t;   // one playback sample, two pipe words

  //////////////////////////////////////////////////////////////////////////
  // player fsm
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    PLAY_IDLE,   // run low, sample address parked at 0
    PLAY_RUN     // run high, pops step through the samples
  } play_state_t;

endpackage

//--- hw/pipe_port.sv
`timescale 1ns/1ps

// host side of the pipe
// one address counter serves both the write and the read strobe
module pipe_port #(
  parameter int PIPE_ADDR_BITS = 12
) (
  input  logic                      pipe_clk,
  input  logic                      reset,
  input  logic                      pipe_in_write,   // one word in per pulse
  input  logic                      pipe_out_read,   // one word out per pulse
  output logic [PIPE_ADDR_BITS-1:0] pipe_addr
);

  logic step;   // either strobe moves the pointer

  assign step = pipe_in_write || pipe_out_read;

  ////////////////////////////////////////////////////////////////////////////
  // address counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge pipe_clk) begin
    if (reset) begin
      pipe_addr <= '0;   // only reset rewinds the pointer
    end else if (step) begin
      pipe_addr <= pipe_addr + 1'b1;   // natural wrap at 2**PIPE_ADDR_BITS
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // host must not write and read in one cycle
  // memory port A would store and return through the same slot
  a_no_write_and_read : assert property (
    @(posedge pipe_clk) disable iff (reset)
      !(pipe_in_write && pipe_out_read)
  ) else $error("pipe_port: write and read strobe in the same cycle");

endmodule

//--- hw/wave_memory.sv
`timescale 1ns/1ps

// waveform store, asymmetric dual port
// port A: 16 bit read/write from the pipe, read-first
// port B: 32 bit read for playback, low half at the even word
module wave_memory #(
  parameter int PIPE_ADDR_BITS = 12
) (
  input  logic                      pipe_clk,
  input  logic                      pipe_in_write,
  input  logic [PIPE_ADDR_BITS-1:0] pipe_addr,
  input  wave_pkg::pipe_word_t      pipe_in_data,
  output wave_pkg::pipe_word_t      pipe_out_data,
  input  logic [PIPE_ADDR_BITS-2:0] sample_addr,
  output wave_pkg::wave_word_t      sample_data
);

  localparam int SAMPLE_BITS  = PIPE_ADDR_BITS - 1;
  localparam int SAMPLE_DEPTH = 2 ** SAMPLE_BITS;

  logic [SAMPLE_BITS-1:0] row_a;   // pipe word address without the half bit
  logic                   half_a;  // 0 = even bank (low half), 1 = odd bank
  logic                   half_q;  // half select lined up with the read data

  assign row_a  = pipe_addr[PIPE_ADDR_BITS-1:1];
  assign half_a = pipe_addr[0];

  ////////////////////////////////////////////////////////////////////////////
  // two half-word banks
  // bank 0 holds even pipe words, bank 1 holds odd ones
  ////////////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < 2; b++) begin : g_bank
    wave_pkg::pipe_word_t mem [SAMPLE_DEPTH];
    wave_pkg::pipe_word_t a_q;   // port A read register
    wave_pkg::pipe_word_t b_q;   // port B read register

    // port A, write lands only in the bank picked by the address lsb
    always_ff @(posedge pipe_clk) begin
      if (pipe_in_write && (half_a == 1'(b))) begin
        mem[row_a] <= pipe_in_data;
      end
      a_q <= mem[row_a];   // old word on a same-cycle write
    end

    // port B, both banks read the same row
    always_ff @(posedge pipe_clk) begin
      b_q <= mem[sample_addr];
    end
  end

  always_ff @(posedge pipe_clk) begin
    half_q <= half_a;
  end

  // pick the bank that was addressed at the strobe
  assign pipe_out_data = half_q ? g_bank[1].a_q : g_bank[0].a_q;

  // word 2k+1 on top, word 2k below
  assign sample_data = {g_bank[1].b_q, g_bank[0].b_q};

endmodule

//--- hw/wave_player.sv
`timescale 1ns/1ps

// playback sequencer
// run arms it, each pop hands out the next sample address
module wave_player #(
  parameter int PIPE_ADDR_BITS = 12
) (
  input  logic                      pipe_clk,
  input  logic                      reset,
  input  logic                      run,     // level, playback enable
  input  logic                      pop,     // pulse, one sample wanted
  output logic [PIPE_ADDR_BITS-2:0] sample_addr,
  output logic                      fetch    // pulse, sample_addr is live
);

  localparam int SAMPLE_BITS = PIPE_ADDR_BITS - 1;

  wave_pkg::play_state_t  state;
  logic [SAMPLE_BITS-1:0] next_addr;   // sample for the next accepted pop
  logic                   take;        // accepted pop

  assign take = run && pop;   // pops with run low fall on the floor

  ////////////////////////////////////////////////////////////////////////////
  // fsm and sample counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge pipe_clk) begin
    if (reset) begin
      state       <= wave_pkg::PLAY_IDLE;
      next_addr   <= '0;
      sample_addr <= '0;
      fetch       <= 1'b0;
    end else begin
      fetch <= take;
      case (state)
        wave_pkg::PLAY_IDLE: begin
          sample_addr <= '0;                                 // always start at 0
          next_addr   <= take ? SAMPLE_BITS'(1) : '0;
          if (run) begin
            state <= wave_pkg::PLAY_RUN;
          end
        end
        wave_pkg::PLAY_RUN: begin
          if (!run) begin
            state       <= wave_pkg::PLAY_IDLE;
            sample_addr <= '0;
            next_addr   <= '0;
          end else if (pop) begin
            sample_addr <= next_addr;
            next_addr   <= next_addr + 1'b1;   // wraps at sample depth
          end
        end
        default: state <= wave_pkg::PLAY_IDLE;
      endcase
    end
  end

  // an accepted pop always leaves the fsm in run
  a_no_fetch_idle : assert property (
    @(posedge pipe_clk) disable iff (reset)
      (state == wave_pkg::PLAY_IDLE) |-> !fetch
  ) else $error("wave_player: fetch raised while idle");

endmodule

//--- hw/wave_output.sv
`timescale 1ns/1ps

// sample output register
// catches the port B word one cycle after fetch and flags it
module wave_output (
  input  logic                 pipe_clk,
  input  logic                 reset,
  input  logic                 fetch,         // from the player
  input  wave_pkg::wave_word_t sample_data,   // port B read data
  output wave_pkg::wave_word_t wave,
  output logic                 wave_valid     // one pulse per accepted pop
);

  logic fetch_q;   // fetch aligned to the memory read latency

  ////////////////////////////////////////////////////////////////////////////
  // capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge pipe_clk) begin
    if (reset) begin
      fetch_q    <= 1'b0;
      wave       <= '0;
      wave_valid <= 1'b0;
    end else begin
      fetch_q    <= fetch;
      wave_valid <= fetch_q;   // two edges after the pop
      if (fetch_q) begin
        wave <= sample_data;   // otherwise hold the last sample
      end
    end
  end

  // wave only moves together with a valid pulse
  a_wave_hold : assert property (
    @(posedge pipe_clk) disable iff (reset)
      (!wave_valid && !$past(reset)) |-> $stable(wave)
  ) else $error("wave_output: wave changed without wave_valid");

endmodule

//--- hw/waveform_from_pipe_bram.sv
`timescale 1ns/1ps

// waveform playback buffer
// host fills the memory through the pipe, playback pops 32 bit samples
module waveform_from_pipe_bram #(
  parameter int PIPE_ADDR_BITS = 12   // 4096 pipe words, 2048 samples
) (
  input  logic                 pipe_clk,
  input  logic                 reset,
  input  logic                 pipe_in_write,
  input  wave_pkg::pipe_word_t pipe_in_data,
  input  logic                 pipe_out_read,
  output wave_pkg::pipe_word_t pipe_out_data,
  input  logic                 run,
  input  logic                 pop,
  output wave_pkg::wave_word_t wave,
  output logic                 wave_valid
);

  logic [PIPE_ADDR_BITS-1:0] pipe_addr;     // shared pipe pointer
  logic [PIPE_ADDR_BITS-2:0] sample_addr;   // playback row
  logic                      fetch;
  wave_pkg::wave_word_t      sample_data;

  ////////////////////////////////////////////////////////////////////////////
  // pipe side
  ////////////////////////////////////////////////////////////////////////////

  pipe_port #(
    .PIPE_ADDR_BITS(PIPE_ADDR_BITS)
  ) u_pipe_port (
    .pipe_clk      (pipe_clk),
    .reset         (reset),
    .pipe_in_write (pipe_in_write),
    .pipe_out_read (pipe_out_read),
    .pipe_addr     (pipe_addr)
  );

  wave_memory #(
    .PIPE_ADDR_BITS(PIPE_ADDR_BITS)
  ) u_wave_memory (
    .pipe_clk      (pipe_clk),
    .pipe_in_write (pipe_in_write),   // straight from the host
    .pipe_addr     (pipe_addr),
    .pipe_in_data  (pipe_in_data),
    .pipe_out_data (pipe_out_data),
    .sample_addr   (sample_addr),
    .sample_data   (sample_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // playback side
  ////////////////////////////////////////////////////////////////////////////

  wave_player #(
    .PIPE_ADDR_BITS(PIPE_ADDR_BITS)
  ) u_wave_player (
    .pipe_clk    (pipe_clk),
    .reset       (reset),
    .run         (run),
    .pop         (pop),
    .sample_addr (sample_addr),
    .fetch       (fetch)
  );

  wave_output u_wave_output (
    .pipe_clk    (pipe_clk),
    .reset       (reset),
    .fetch       (fetch),
    .sample_data (sample_data),
    .wave        (wave),
    .wave_valid  (wave_valid)
  );

endmodule

//--- tests/waveform_tb.sv
`timescale 1ns/1ps

module waveform_tb;

  localparam int ADDR_BITS    = 6;                    // small memory so the wrap comes cheap
  localparam int WORDS        = 2 ** ADDR_BITS;       // 64 pipe words
  localparam int SAMPLES      = WORDS / 2;            // 32 samples
  localparam int CLK_NS       = 100;
  localparam int NUM_STEPS    = 19;
  localparam int WATCH_CYCLES = (4 + 64 + 64 + 80 + 40) * 2;

  logic                 pipe_clk;
  logic                 reset;
  logic                 pipe_in_write;
  wave_pkg::pipe_word_t pipe_in_data;
  logic                 pipe_out_read;
  wave_pkg::pipe_word_t pipe_out_data;
  logic                 run;
  logic                 pop;
  wave_pkg::wave_word_t wave;
  logic                 wave_valid;

  wave_pkg::pipe_word_t word_table [WORDS];   // lcg fill
  wave_pkg::pipe_word_t model_mem [WORDS];    // mirror of the memory
  logic [31:0]          lcg_state;
  int                   errors;
  int                   pipe_ptr;             // model of the pipe address
  int                   play_addr;            // model of the next sample
  int                   valid_count;
  logic                 pend_v [2];           // pops still in flight
  wave_pkg::wave_word_t pend_d [2];
  wave_pkg::wave_word_t exp_wave;
  wave_pkg::pipe_word_t new_word;

  //////////////////////////////////////////////////////////////////////////
  // playback steps as {run, pop, cycles}
  //////////////////////////////////////////////////////////////////////////

  logic [9:0] step_table [NUM_STEPS] = '{
    {1'b0, 1'b1, 8'd1},    // pop with run low
    {1'b0, 1'b0, 8'd4},    // nothing may come out
    {1'b1, 1'b0, 8'd1},    // raise run
    {1'b1, 1'b1, 8'd32},   // whole memory back to back
    {1'b1, 1'b0, 8'd3},    // drain
    {1'b1, 1'b1, 8'd1},    // wraps back to sample 0
    {1'b1, 1'b0, 8'd4},
    {1'b1, 1'b1, 8'd1},
    {1'b1, 1'b0, 8'd3},
    {1'b1, 1'b1, 8'd2},
    {1'b1, 1'b0, 8'd4},
    {1'b0, 1'b0, 8'd2},    // drop run
    {1'b0, 1'b1, 8'd1},    // ignored
    {1'b1, 1'b0, 8'd1},    // rearm
    {1'b1, 1'b1, 8'd1},    // back at sample 0
    {1'b1, 1'b0, 8'd3},
    {1'b0, 1'b0, 8'd2},    // replay after the overwrite
    {1'b1, 1'b1, 8'd1},
    {1'b1, 1'b0, 8'd3}
  };

  waveform_from_pipe_bram #(
    .PIPE_ADDR_BITS(ADDR_BITS)
  ) UUT (
    .pipe_clk      (pipe_clk),
    .reset         (reset),
    .pipe_in_write (pipe_in_write),
    .pipe_in_data  (pipe_in_data),
    .pipe_out_read (pipe_out_read),
    .pipe_out_data (pipe_out_data),
    .run           (run),
    .pop           (pop),
    .wave          (wave),
    .wave_valid    (wave_valid)
  );

  initial begin
    pipe_clk = 1'b0;
    forever #(CLK_NS / 2) pipe_clk = ~pipe_clk;
  end

  // hang guard
  initial begin
    #(WATCH_CYCLES * CLK_NS);
    $display("timeout: run did not finish within %0d clock cycles", WATCH_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // sample k with the odd word on top
  function automatic wave_pkg::wave_word_t sample_of(input int k);
    return {model_mem[2 * k + 1], model_mem[2 * k]};
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // starts and ends on a falling edge
  task automatic apply_reset(input int cycles);
    reset = 1'b1;
    repeat (cycles) @(negedge pipe_clk);
    reset       = 1'b0;
    pipe_ptr    = 0;   // memory model kept
    play_addr   = 0;
    pend_v[0]   = 1'b0;
    pend_v[1]   = 1'b0;
    exp_wave    = '0;
  endtask

  task automatic pipe_write(input wave_pkg::pipe_word_t d);
    pipe_in_write       = 1'b1;
    pipe_in_data        = d;
    model_mem[pipe_ptr] = d;
    pipe_ptr            = (pipe_ptr + 1) % WORDS;
    @(negedge pipe_clk);
    pipe_in_write = 1'b0;
  endtask

  // word shows up one edge after the strobe
  task automatic pipe_read(input wave_pkg::pipe_word_t exp, input int idx);
    pipe_out_read = 1'b1;
    pipe_ptr      = (pipe_ptr + 1) % WORDS;
    @(negedge pipe_clk);
    pipe_out_read = 1'b0;
    check_value(32'(pipe_out_data), 32'(exp), $sformatf("pipe read of word %0d", idx));
  endtask

  // one clock of playback with the model alongside
  task automatic play_cycle(input logic r, input logic p);
    logic                 out_v;
    wave_pkg::wave_word_t out_d;
    run = r;
    pop = p;
    @(negedge pipe_clk);
    out_v     = pend_v[1];            // pop from two edges back
    out_d     = pend_d[1];
    pend_v[1] = pend_v[0];
    pend_d[1] = pend_d[0];
    pend_v[0] = r && p;
    pend_d[0] = sample_of(play_addr);
    if (!r) begin
      play_addr = 0;                  // idle parks at sample 0
    end else if (p) begin
      play_addr = (play_addr + 1) % SAMPLES;
    end
    if (out_v) begin
      exp_wave = out_d;               // else wave must hold
    end
    check_value(32'(wave_valid), 32'(out_v), "wave_valid");
    check_value(wave, exp_wave, "wave");
    if (wave_valid) begin
      valid_count++;
    end
  endtask

  task automatic apply_steps(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      repeat (int'(step_table[i][7:0])) play_cycle(step_table[i][9], step_table[i][8]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    errors        = 0;
    valid_count   = 0;
    reset         = 1'b1;
    pipe_in_write = 1'b0;
    pipe_in_data  = '0;
    pipe_out_read = 1'b0;
    run           = 1'b0;
    pop           = 1'b0;
    lcg_state     = 32'd93643;
    for (int i = 0; i < WORDS; i++) begin
      lcg_state     = lcg_next(lcg_state);
      word_table[i] = lcg_state[31:16];
      model_mem[i]  = '0;
    end
    apply_reset(4);

    // idle outputs and a pop ignored while run is low
    check_value(32'(wave_valid), 32'd0, "wave_valid after reset");
    check_value(wave, 32'd0, "wave after reset");
    apply_steps(0, 1);
    check_value(32'(valid_count), 32'd0, "valid pulses with run low");

    // fill and reset with the array kept, then read back in order
    for (int i = 0; i < WORDS; i++) begin
      pipe_write(word_table[i]);
    end
    apply_reset(2);
    for (int i = 0; i < WORDS; i++) begin
      pipe_read(word_table[i], i);
    end

    // full playback with the 2 cycle latency checked per cycle
    valid_count = 0;
    apply_steps(2, 4);
    check_value(32'(valid_count), 32'd32, "valid pulses for 32 pops");

    apply_steps(5, 10);   // wrap and hold
    apply_steps(11, 15);  // run toggle
    check_value(wave, sample_of(0), "first sample after run toggle");

    // the pipe address wrapped so this overwrites word 0
    new_word = ~word_table[0];
    pipe_write(new_word);
    apply_steps(16, 18);
    check_value(32'(wave[15:0]), 32'(new_word), "sample 0 low half after overwrite");
    check_value(32'(wave[31:16]), 32'(word_table[1]), "sample 0 high half after overwrite");

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- waveform_from_pipe_bram.f
hw/wave_pkg.sv
hw/pipe_port.sv
hw/wave_memory.sv
hw/wave_player.sv
hw/wave_output.sv
hw/waveform_from_pipe_bram.sv
tests/waveform_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := waveform_tb
RTL_TOP    := waveform_from_pipe_bram
FILELIST   := waveform_from_pipe_bram.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
PASS_MSG   := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
